// File: include/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Request queue entries, equal to the upstream credits held after reset
`define LSU_REQ_DEPTH 4

// Response queue entries
// Also caps the loads in flight and sizes the tag queue
`define LSU_RSP_DEPTH 4

// Credits granted by the downstream consumer after reset
`define LSU_RSP_CREDITS 2

// Byte address width on the pipeline side and on the bus
`define LSU_ADDR_W 32

`endif

// File: rtl/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

  // Load type, same order as the core's MEM_OP codes
  typedef enum logic [2:0] {
    MEM_OP_B  = 3'd0,  // Signed byte
    MEM_OP_BU = 3'd1,  // Unsigned byte
    MEM_OP_H  = 3'd2,  // Signed halfword
    MEM_OP_HU = 3'd3,  // Unsigned halfword
    MEM_OP_W  = 3'd4   // Full word
  } mem_op_e;

  // Load request from the pipeline
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;  // Byte address
    mem_op_e                op;
  } load_req_t;

  // Per-load bookkeeping handed from bus issue to the aligner
  typedef struct packed {
    logic [1:0] offset;    // Byte offset in the first word
    mem_op_e    op;
    logic       two_beat;  // Crosses a word boundary
  } load_tag_t;

  // Extended load result
  typedef struct packed {
    logic [31:0] data;
  } load_rsp_t;

  // Read command on the memory bus
  typedef struct packed {
    logic                   read;
    logic [`LSU_ADDR_W-1:0] addr;  // Word aligned
  } bus_req_t;

endpackage

// File: rtl/lsu_fifo.sv
`timescale 1ns/10ps

module lsu_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           rest,
  input  logic                           push,
  input  T                               push_data,
  input  logic                           pop,
  output T                               head,
  output logic                           empty,
  output logic [$clog2(DEPTH+1)-1:0]     count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign empty   = (count == '0);
  assign do_push = push && (count != DEPTH[$clog2(DEPTH+1)-1:0]);  // Drop on full
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/lsu_bus_issue.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_bus_issue (
  input  logic                                 clk,
  input  logic                                 rest,
  input  lsu_pkg::load_req_t                   req_head,
  input  logic                                 req_empty,
  output logic                                 req_pop,
  output logic                                 req_credit,
  output lsu_pkg::bus_req_t                    bus,
  input  logic                                 bus_waitrequest,
  output logic                                 tag_push,
  output lsu_pkg::load_tag_t                   tag,
  input  logic [$clog2(`LSU_RSP_DEPTH+1)-1:0]  rsp_count,
  input  logic                                 rsp_push
);

  import lsu_pkg::*;

  localparam int CW = $clog2(`LSU_RSP_DEPTH + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BEAT0,
    ST_BEAT1
  } state_e;

  state_e        state;
  logic [CW-1:0] inflight;
  logic [CW:0]   reserved;
  logic [2:0]    req_size;
  logic          req_two_beat;
  logic          beat_accept;

  function automatic logic [2:0] op_size(mem_op_e op);
    case (op)
      MEM_OP_B, MEM_OP_BU: op_size = 3'd1;
      MEM_OP_H, MEM_OP_HU: op_size = 3'd2;
      default:             op_size = 3'd4;
    endcase
  endfunction

  assign reserved     = {1'b0, inflight} + {1'b0, rsp_count};  // Response slots spoken for
  assign req_size     = op_size(req_head.op);
  assign req_two_beat = ({1'b0, req_head.addr[1:0]} + req_size) > 3'd4;

  assign req_pop     = (state == ST_IDLE) && !req_empty && (reserved < `LSU_RSP_DEPTH);
  assign beat_accept = bus.read && !bus_waitrequest;
  assign tag_push    = (state == ST_BEAT0) && beat_accept;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state <= ST_IDLE;
      bus   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_pop) begin
            bus.read <= 1'b1;
            bus.addr <= {req_head.addr[`LSU_ADDR_W-1:2], 2'b00};
            state    <= ST_BEAT0;
          end
        end
        ST_BEAT0: begin
          if (beat_accept) begin
            if (tag.two_beat) begin
              bus.addr <= bus.addr + 'd4;  // Next word
              state    <= ST_BEAT1;
            end else begin
              bus.read <= 1'b0;
              state    <= ST_IDLE;
            end
          end
        end
        ST_BEAT1: begin
          if (beat_accept) begin
            bus.read <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_pop) begin
      tag.offset   <= req_head.addr[1:0];
      tag.op       <= req_head.op;
      tag.two_beat <= req_two_beat;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      inflight   <= '0;
      req_credit <= 1'b0;
    end else begin
      req_credit <= req_pop;  // One credit back per popped entry
      case ({tag_push, rsp_push})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

endmodule

// File: rtl/lsu_read_align.sv
`timescale 1ns/10ps

module lsu_read_align (
  input  logic               clk,
  input  logic               rest,
  input  lsu_pkg::load_tag_t tag_head,
  output logic               tag_pop,
  input  logic [31:0]        bus_rdata,
  input  logic               bus_rdata_valid,
  output logic               rsp_push,
  output lsu_pkg::load_rsp_t rsp
);

  import lsu_pkg::*;

  logic        have_first;
  logic [31:0] beat_buf;
  logic        final_beat;
  logic [31:0] lo_word;
  logic [31:0] aligned;
  logic [31:0] extended;

  assign final_beat = bus_rdata_valid && (!tag_head.two_beat || have_first);
  assign tag_pop    = final_beat;  // Tag fields are consumed here
  assign lo_word    = tag_head.two_beat ? beat_buf : bus_rdata;

  // Byte rotation by offset, upper bytes come from the current beat
  always_comb begin
    case (tag_head.offset)
      2'd1:    aligned = {bus_rdata[7:0],  lo_word[31:8]};
      2'd2:    aligned = {bus_rdata[15:0], lo_word[31:16]};
      2'd3:    aligned = {bus_rdata[23:0], lo_word[31:24]};
      default: aligned = lo_word;
    endcase
  end

  always_comb begin
    case (tag_head.op)
      MEM_OP_B:  extended = {{24{aligned[7]}}, aligned[7:0]};
      MEM_OP_BU: extended = {24'd0, aligned[7:0]};
      MEM_OP_H:  extended = {{16{aligned[15]}}, aligned[15:0]};
      MEM_OP_HU: extended = {16'd0, aligned[15:0]};
      default:   extended = aligned;
    endcase
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      have_first <= 1'b0;
      rsp_push   <= 1'b0;
    end else begin
      rsp_push <= final_beat;
      if (bus_rdata_valid) begin
        have_first <= !final_beat;  // Set only after a first beat
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_rdata_valid && !final_beat) begin
      beat_buf <= bus_rdata;
    end
    if (final_beat) begin
      rsp.data <= extended;
    end
  end

endmodule

// File: rtl/lsu_rsp_credit.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_rsp_credit (
  input  logic               clk,
  input  logic               rest,
  input  logic               rsp_empty,
  input  lsu_pkg::load_rsp_t rsp_head,
  output logic               rsp_pop,
  input  logic               rsp_credit,
  output logic               rsp_valid,
  output lsu_pkg::load_rsp_t rsp
);

  localparam int KW = $clog2(`LSU_RSP_CREDITS + 1);

  logic [KW-1:0] credit;

  // Credit still free once the response on the wire is paid for
  assign rsp_pop = !rsp_empty && (credit > KW'(rsp_valid));

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      credit    <= KW'(`LSU_RSP_CREDITS);
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rsp_pop;
      case ({rsp_valid, rsp_credit})
        2'b10:   credit <= credit - 1'b1;  // Spent
        2'b01:   credit <= credit + 1'b1;  // Returned
        default: credit <= credit;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_pop) begin
      rsp <= rsp_head;
    end
  end

endmodule

// File: rtl/lsu_load_unit.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_load_unit (
  input  logic               clk,
  input  logic               rest,
  input  logic               req_valid,
  input  lsu_pkg::load_req_t req,
  output logic               req_credit,
  output lsu_pkg::bus_req_t  bus,
  input  logic               bus_waitrequest,
  input  logic [31:0]        bus_rdata,
  input  logic               bus_rdata_valid,
  output logic               rsp_valid,
  output lsu_pkg::load_rsp_t rsp,
  input  logic               rsp_credit
);

  import lsu_pkg::*;

  load_req_t req_head;
  logic      req_empty;
  logic      req_pop;

  load_tag_t tag_in;
  load_tag_t tag_head;
  logic      tag_push;
  logic      tag_pop;

  load_rsp_t                           rsp_in;
  load_rsp_t                           rsp_head;
  logic                                rsp_push;
  logic                                rsp_empty;
  logic                                rsp_pop;
  logic [$clog2(`LSU_RSP_DEPTH+1)-1:0] rsp_count;

  // Credited input queue
  lsu_fifo #(.T(load_req_t), .DEPTH(`LSU_REQ_DEPTH)) u_req_q (
    .clk       (clk),
    .rest      (rest),
    .push      (req_valid),
    .push_data (req),
    .pop       (req_pop),
    .head      (req_head),
    .empty     (req_empty),
    .count     ()
  );

  lsu_bus_issue u_bus_issue (
    .clk             (clk),
    .rest            (rest),
    .req_head        (req_head),
    .req_empty       (req_empty),
    .req_pop         (req_pop),
    .req_credit      (req_credit),
    .bus             (bus),
    .bus_waitrequest (bus_waitrequest),
    .tag_push        (tag_push),
    .tag             (tag_in),
    .rsp_count       (rsp_count),
    .rsp_push        (rsp_push)
  );

  // Loads on the bus, in issue order
  lsu_fifo #(.T(load_tag_t), .DEPTH(`LSU_RSP_DEPTH)) u_tag_q (
    .clk       (clk),
    .rest      (rest),
    .push      (tag_push),
    .push_data (tag_in),
    .pop       (tag_pop),
    .head      (tag_head),
    .empty     (),
    .count     ()
  );

  lsu_read_align u_read_align (
    .clk             (clk),
    .rest            (rest),
    .tag_head        (tag_head),
    .tag_pop         (tag_pop),
    .bus_rdata       (bus_rdata),
    .bus_rdata_valid (bus_rdata_valid),
    .rsp_push        (rsp_push),
    .rsp             (rsp_in)
  );

  lsu_fifo #(.T(load_rsp_t), .DEPTH(`LSU_RSP_DEPTH)) u_rsp_q (
    .clk       (clk),
    .rest      (rest),
    .push      (rsp_push),
    .push_data (rsp_in),
    .pop       (rsp_pop),
    .head      (rsp_head),
    .empty     (rsp_empty),
    .count     (rsp_count)
  );

  lsu_rsp_credit u_rsp_credit (
    .clk        (clk),
    .rest       (rest),
    .rsp_empty  (rsp_empty),
    .rsp_head   (rsp_head),
    .rsp_pop    (rsp_pop),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

// File: dv/lsu_asserts.sv
`timescale 1ns/10ps

module lsu_asserts (
  input logic              clk,
  input logic              rest,
  input lsu_pkg::bus_req_t bus,
  input logic              bus_waitrequest,
  input logic              rsp_valid,
  input logic              req_credit
);

  // Read command held until the bus takes it
  a_bus_hold: assert property (@(posedge clk) disable iff (!rest)
    bus.read && bus_waitrequest |=> bus.read && $stable(bus.addr))
    else $error("Bus read dropped or moved while waitrequest was high");

  // Nothing can fire on the first clock out of reset
  a_reset_exit: assert property (@(posedge clk)
    $rose(rest) |=> !bus.read && !rsp_valid && !req_credit)
    else $error("Bus strobe, rsp_valid or req_credit active in the first cycle after reset");

endmodule

bind lsu_load_unit lsu_asserts u_asserts (
  .clk             (clk),
  .rest            (rest),
  .bus             (bus),
  .bus_waitrequest (bus_waitrequest),
  .rsp_valid       (rsp_valid),
  .req_credit      (req_credit)
);

// File: dv/lsu_checker.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_checker (
  input  logic               clk,
  input  logic               rest,
  input  logic               req_valid,
  input  logic               req_credit,
  input  logic               rsp_valid,
  input  lsu_pkg::load_rsp_t rsp,
  input  logic               rsp_credit,
  input  logic [31:0]        exp_data,
  input  int                 n_loads,
  input  logic               end_check,
  output int                 rsp_seen,
  output int                 value_errs,
  output int                 credit_errs,
  output int                 count_errs
);

  int   credit;  // Consumer credit as the testbench sees it
  int   req_sent;
  int   req_back;
  logic ended;

  always @(posedge clk) begin
    if (!rest) begin
      credit      = `LSU_RSP_CREDITS;
      req_sent    = 0;
      req_back    = 0;
      rsp_seen    = 0;
      value_errs  = 0;
      credit_errs = 0;
      count_errs  = 0;
      ended       = 1'b0;
    end else begin
      req_sent += int'(req_valid);
      req_back += int'(req_credit);
      if (rsp_valid) begin
        if (credit <= 0) begin
          $display("Response sent with no consumer credit left at %0t", $time);
          credit_errs++;
        end
        if (rsp_seen >= n_loads) begin
          $display("Extra response %08h after every load was answered", rsp.data);
          count_errs++;
        end else if (rsp.data !== exp_data) begin
          $display("Fail rsp load %0d: expected %08h, actual %08h", rsp_seen, exp_data,
                   rsp.data);
          value_errs++;
        end
        rsp_seen++;
        credit--;
      end
      credit += int'(rsp_credit);
      if (end_check && !ended) begin
        ended = 1'b1;
        if (rsp_seen != n_loads) begin
          $display("Got %0d responses for %0d loads", rsp_seen, n_loads);
          count_errs++;
        end
        if (req_back != req_sent || req_sent != n_loads) begin
          $display("Request credits returned %0d for %0d requests", req_back, req_sent);
          count_errs++;
        end
      end
    end
  end

endmodule

// File: dv/lsu_tb.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_tb;

  import lsu_pkg::*;

  logic        clk;
  logic        rest;
  logic        req_valid;
  load_req_t   req;
  logic        req_credit;
  bus_req_t    bus;
  logic        bus_waitrequest;
  logic [31:0] bus_rdata;
  logic        bus_rdata_valid;
  logic        rsp_valid;
  load_rsp_t   rsp;
  logic        rsp_credit;

  logic [34:0] stim_req [64];  // Address and op of each load
  logic [31:0] stim_exp [64];
  logic [31:0] exp_data;
  int          n_loads = 0;
  logic        end_check;
  int          rsp_seen;
  int          value_errs;
  int          credit_errs;
  int          count_errs;

  logic [15:0] lfsr = 16'd55362;
  logic [31:0] rd_q [$];  // Accepted reads waiting for data
  logic [31:0] rd_addr;
  int          ret_gap = 0;
  int          crd_owed = 0;
  int          crd_gap = 0;
  int          starve = 0;
  int          rsp_total = 0;

  assign exp_data = stim_exp[rsp_seen[5:0]];

  lsu_load_unit u_dut (.*);
  lsu_checker   u_chk (.*);

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Byte b of memory holds b*7+3
  function automatic logic [31:0] mem_word(logic [31:0] waddr);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = 8'((waddr + 32'(i)) * 32'd7 + 32'd3);
    end
    return w;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    int          fd;
    int          got;
    int          idx;
    int          req_cr;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    rest            = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    bus_waitrequest = 1'b0;
    bus_rdata       = '0;
    bus_rdata_valid = 1'b0;
    rsp_credit      = 1'b0;
    end_check       = 1'b0;
    fd = $fopen("dv/lsu_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/lsu_stim.txt");
    end else begin
      while (!$feof(fd) && n_loads < 64) begin
        got = $fgets(line, fd);
        got = $sscanf(line, "%h %h %h", op, addr, data);
        if (got == 3) begin
          stim_req[n_loads] = {addr, op[2:0]};
          stim_exp[n_loads] = data;
          n_loads++;
        end
      end
      $fclose(fd);
    end
    repeat (8) @(posedge clk);
    rest <= 1'b1;
    req_cr = `LSU_REQ_DEPTH;
    idx    = 0;
    while (idx < n_loads) begin
      @(posedge clk);
      req_cr += int'(req_credit);
      req_valid <= (req_cr > 0);
      if (req_cr > 0) begin
        req <= stim_req[idx];
        req_cr--;
        idx++;
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;
    wait (rsp_seen >= n_loads);
    repeat (40) @(posedge clk);  // Window for a stray extra response
    end_check <= 1'b1;
    repeat (2) @(posedge clk);
    $display("Errors: %0d value, %0d credit, %0d count", value_errs, credit_errs, count_errs);
    if (value_errs + credit_errs + count_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    @(posedge rest);
    repeat (n_loads * 200) @(posedge clk);
    $display("Timeout: responses stopped arriving after %0d of %0d loads", rsp_seen, n_loads);
    $display("Simulation FAILED");
    $finish;
  end

  // Memory with random wait states and return gaps, plus the consumer credit loop
  always @(posedge clk) begin
    if (rest) begin
      if (rd_q.size() > 0 && ret_gap == 0) begin
        rd_addr = rd_q.pop_front();
        bus_rdata       <= mem_word(rd_addr);
        bus_rdata_valid <= 1'b1;
        ret_gap = rand_bits(2);
      end else begin
        bus_rdata_valid <= 1'b0;
        ret_gap = (ret_gap > 0) ? ret_gap - 1 : 0;
      end
      if (bus.read && !bus_waitrequest) begin
        rd_q.push_back(bus.addr);
      end
      bus_waitrequest <= (rand_bits(2) == 0);
      if (rsp_valid) begin
        crd_owed++;
        rsp_total++;
        starve = (rsp_total == 6) ? 120 : starve;  // Long consumer stall
      end
      if (starve > 0) begin
        starve--;
        rsp_credit <= 1'b0;
      end else if (crd_owed > 0 && crd_gap == 0) begin
        rsp_credit <= 1'b1;
        crd_owed--;
        crd_gap = rand_bits(3);
      end else begin
        rsp_credit <= 1'b0;
        crd_gap = (crd_gap > 0) ? crd_gap - 1 : 0;
      end
    end
  end

endmodule

// File: dv/lsu_stim.txt
// Columns: op addr expected, all hex; op 0=B 1=BU 2=H 3=HU 4=W
// Memory byte at address b holds the low 8 bits of b*7+3
0 00000012 ffffff81
1 00000012 00000081
0 00000005 00000026
2 00000014 ffff968f
3 00000014 0000968f
2 00000002 00001811
4 00000018 c0b9b2ab
4 00000000 18110a03
0 00000023 fffffff8
1 00000024 000000ff
2 00000007 00003b34
3 0000001f 0000e3dc
2 0000001f ffffe3dc
4 00000021 fff8f1ea
4 0000000a 5e575049
4 00000017 b9b2aba4
4 80000014 a49d968f
3 00000026 0000140d
4 00000025 1b140d06
1 0000001b 000000c0

// File: build.f
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_fifo.sv
rtl/lsu_bus_issue.sv
rtl/lsu_read_align.sv
rtl/lsu_rsp_credit.sv
rtl/lsu_load_unit.sv
dv/lsu_asserts.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
  -f build.f --top-module lsu_tb -o lsu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
  echo "Run passed"
  exit 0
fi
echo "Run failed"
exit 1
